// ==== verilog/ll_config.svh ====
// Width settings for the single-channel logic link
// Included by the packages, the RTL blocks and the testbench
// All block widths derive from these values, modules take no parameters

`ifndef LL_CONFIG_SVH
`define LL_CONFIG_SVH

// User data field of a flit
`define LL_DATA_W 32

// Flat flit: state, protid, data, dvalid, crc, crc_valid, valid
`define LL_FLIT_W 45

// PHY word: marker on top, flit, strobe in bit 0
`define LL_PHY_W 50

// Automatic marker user bits
`define LL_MRK_W 4

// Bring-up delay counters
`define LL_DLY_W 16

// Valid-flit debug counters
`define LL_DBG_W 16

`endif

// ==== verilog/lpif_pkg.sv ====
// Link-layer side types of the logic link
// Holds the LPIF state and protocol id encodings and the flit layout
// Import with lpif_pkg::* in a module body, scoped names in port lists

`default_nettype none

`include "ll_config.svh"

package lpif_pkg;

  // LPIF link state, 4-bit encoding as seen on the user bus
  typedef enum logic [3:0] {
    LPIF_ST_RESET    = 4'h0,
    LPIF_ST_ACTIVE   = 4'h1,
    LPIF_ST_IDLE     = 4'h4,
    LPIF_ST_LINKERR  = 4'hA,
    LPIF_ST_RETRAIN  = 4'hB,
    LPIF_ST_DISABLED = 4'hC
  } lpif_state_e;

  // Protocol carried by the flit
  typedef enum logic [1:0] {
    LPIF_PROT_PCIE      = 2'd0,
    LPIF_PROT_CXL_IO    = 2'd1,
    LPIF_PROT_CXL_CACHE = 2'd2,
    LPIF_PROT_CXL_MEM   = 2'd3
  } lpif_protid_e;

  // One flit, MSB first; totals LL_FLIT_W bits
  typedef struct packed {
    lpif_state_e         state;
    lpif_protid_e        protid;
    logic [`LL_DATA_W-1:0] data;
    logic                dvalid;
    logic [3:0]          crc;
    logic                crc_valid;
    // Flit strobe, no other handshake
    logic                valid;
  } lpif_flit_t;

endpackage

`default_nettype wire

// ==== verilog/phy_pkg.sv ====
// PHY side types of the logic link
// Holds the bring-up FSM states and the layout of the parallel PHY word

`default_nettype none

`include "ll_config.svh"

package phy_pkg;

  // Transmit bring-up
  typedef enum logic [1:0] {
    TX_OFFLINE = 2'd0,
    TX_WAIT_Z  = 2'd1,
    TX_ONLINE  = 2'd2
  } tx_sync_e;

  // Receive bring-up, x count then gated y count
  typedef enum logic [1:0] {
    RX_OFFLINE = 2'd0,
    RX_WAIT_X  = 2'd1,
    RX_WAIT_Y  = 2'd2,
    RX_ONLINE  = 2'd3
  } rx_sync_e;

  // PHY word, LL_PHY_W bits
  typedef struct packed {
    logic [`LL_MRK_W-1:0]  marker;
    logic [`LL_FLIT_W-1:0] flit;
    // Strobe user bit sits in bit 0
    logic                  strobe;
  } phy_word_t;

endpackage

`default_nettype wire

// ==== verilog/ll_sync_if.sv ====
// Bring-up levels and automatic user bits of the logic link
// Driven by the sync control block, read by the PHY mapper

`default_nettype none

`include "ll_config.svh"

interface ll_sync_if;

  // Delayed online levels
  logic                 tx_online_delay;
  logic                 rx_online_delay;

  // Persistent user bits for the PHY word
  logic [`LL_MRK_W-1:0] auto_mrk;
  logic                 auto_stb;

  // Control side
  modport sync (output tx_online_delay, rx_online_delay, auto_mrk, auto_stb);

  // PHY mapper side
  modport phy (input tx_online_delay, rx_online_delay, auto_mrk, auto_stb);

endinterface

`default_nettype wire

// ==== verilog/ll_auto_sync.sv ====
// Bring-up control of the logic link
// Delays tx_online by delay_z_value cycles, and rx_online by delay_x_value
// cycles followed by delay_y_value cycles counted only while tx is up.
// Also drives the persistent strobe and marker user bits while tx is
// requested. Results leave on the sync modport of ll_sync_if.

`default_nettype none

`include "ll_config.svh"

module ll_auto_sync (
  input  logic                 clk_wr,
  input  logic                 arst_n,
  input  logic                 tx_online,
  input  logic                 rx_online,
  input  logic [`LL_DLY_W-1:0] delay_x_value,
  input  logic [`LL_DLY_W-1:0] delay_y_value,
  input  logic [`LL_DLY_W-1:0] delay_z_value,
  input  logic [`LL_MRK_W-1:0] tx_mrk_userbit,
  input  logic                 tx_stb_userbit,
  ll_sync_if.sync              sync
);

  import phy_pkg::*;

  tx_sync_e             tx_state;
  rx_sync_e             rx_state;
  logic [`LL_DLY_W-1:0] tx_cnt;
  logic [`LL_DLY_W-1:0] rx_cnt;
  logic                 tx_online_dly;
  logic                 rx_online_dly;

  ////////////////////////////////////////////////////////////
  // Tx bring-up

  // Count loaded on first high sample
  // Level rises z edges later
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_state <= TX_OFFLINE;
      tx_cnt   <= '0;
    end else begin
      case (tx_state)
        TX_OFFLINE: begin
          if (tx_online) begin
            tx_state <= TX_WAIT_Z;
            tx_cnt   <= delay_z_value;
          end
        end
        TX_WAIT_Z: begin
          if (!tx_online)
            tx_state <= TX_OFFLINE;
          else if (tx_cnt == `LL_DLY_W'(1))
            tx_state <= TX_ONLINE;
          else
            tx_cnt <= tx_cnt - `LL_DLY_W'(1);
        end
        // Drop on first low sample
        default: begin
          if (!tx_online)
            tx_state <= TX_OFFLINE;
        end
      endcase
    end
  end

  assign tx_online_dly = (tx_state == TX_ONLINE);

  ////////////////////////////////////////////////////////////
  // Rx bring-up

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_state <= RX_OFFLINE;
      rx_cnt   <= '0;
    end else begin
      case (rx_state)
        RX_OFFLINE: begin
          if (rx_online) begin
            rx_state <= RX_WAIT_X;
            rx_cnt   <= delay_x_value;
          end
        end
        // Word alignment wait
        RX_WAIT_X: begin
          if (!rx_online) begin
            rx_state <= RX_OFFLINE;
          end else if (rx_cnt == `LL_DLY_W'(1)) begin
            rx_state <= RX_WAIT_Y;
            rx_cnt   <= delay_y_value;
          end else begin
            rx_cnt <= rx_cnt - `LL_DLY_W'(1);
          end
        end
        // Y count frozen while the tx side is down
        RX_WAIT_Y: begin
          if (!rx_online) begin
            rx_state <= RX_OFFLINE;
          end else if (tx_online_dly) begin
            // Never go online on the edge that drops tx
            if (rx_cnt == `LL_DLY_W'(1)) begin
              if (tx_online)
                rx_state <= RX_ONLINE;
            end else begin
              rx_cnt <= rx_cnt - `LL_DLY_W'(1);
            end
          end
        end
        default: begin
          if (!rx_online || !tx_online)
            rx_state <= RX_OFFLINE;
        end
      endcase
    end
  end

  assign rx_online_dly = (rx_state == RX_ONLINE);

  ////////////////////////////////////////////////////////////
  // Persistent user bits

  // Follow the user bits whenever tx is requested
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      sync.auto_mrk <= '0;
      sync.auto_stb <= 1'b0;
    end else if (tx_online) begin
      sync.auto_mrk <= tx_mrk_userbit;
      sync.auto_stb <= tx_stb_userbit;
    end else begin
      sync.auto_mrk <= '0;
      sync.auto_stb <= 1'b0;
    end
  end

  assign sync.tx_online_delay = tx_online_dly;
  assign sync.rx_online_delay = rx_online_dly;

  // Rx never online without tx
  a_rx_needs_tx: assert property (@(posedge clk_wr) disable iff (!arst_n)
    rx_online_dly |-> tx_online_dly);

  // Tx level only rises after a high tx_online sample
  a_tx_rise_on_req: assert property (@(posedge clk_wr) disable iff (!arst_n)
    $rose(tx_online_dly) |-> $past(tx_online));

endmodule

`default_nettype wire

// ==== verilog/ll_flit_pack.sv ====
// Flit packing and unpacking of the logic link
// Upstream user fields become one flat flit, combinationally.
// The received flit is registered onto the downstream user fields.
// Two wrapping counters of valid flits feed the debug status outputs.

`default_nettype none

`include "ll_config.svh"

module ll_flit_pack (
  input  logic                  clk_wr,
  input  logic                  arst_n,
  // Upstream user fields
  input  lpif_pkg::lpif_state_e  ustrm_state,
  input  lpif_pkg::lpif_protid_e ustrm_protid,
  input  logic [`LL_DATA_W-1:0] ustrm_data,
  input  logic                  ustrm_dvalid,
  input  logic [3:0]            ustrm_crc,
  input  logic                  ustrm_crc_valid,
  input  logic                  ustrm_valid,
  // Flits to and from the PHY mapper
  input  lpif_pkg::lpif_flit_t   rx_flit,
  input  logic                  rx_online,
  output lpif_pkg::lpif_flit_t   tx_flit,
  // Downstream user fields
  output lpif_pkg::lpif_state_e  dstrm_state,
  output lpif_pkg::lpif_protid_e dstrm_protid,
  output logic [`LL_DATA_W-1:0] dstrm_data,
  output logic                  dstrm_dvalid,
  output logic [3:0]            dstrm_crc,
  output logic                  dstrm_crc_valid,
  output logic                  dstrm_valid,
  // Debug counters
  output logic [`LL_DBG_W-1:0]  rx_debug_count,
  output logic [`LL_DBG_W-1:0]  tx_debug_count
);

  import lpif_pkg::*;

  lpif_flit_t           dstrm_q;
  logic [`LL_DBG_W-1:0] rx_cnt;
  logic [`LL_DBG_W-1:0] tx_cnt;

  // Upstream pack of one flit every clock
  assign tx_flit = '{
    state:     ustrm_state,
    protid:    ustrm_protid,
    data:      ustrm_data,
    dvalid:    ustrm_dvalid,
    crc:       ustrm_crc,
    crc_valid: ustrm_crc_valid,
    valid:     ustrm_valid
  };

  // Downstream register as third cycle of the loopback path
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n)
      dstrm_q <= '0;
    else
      dstrm_q <= rx_flit;
  end

  assign dstrm_state     = dstrm_q.state;
  assign dstrm_protid    = dstrm_q.protid;
  assign dstrm_data      = dstrm_q.data;
  assign dstrm_dvalid    = dstrm_q.dvalid;
  assign dstrm_crc       = dstrm_q.crc;
  assign dstrm_crc_valid = dstrm_q.crc_valid;
  assign dstrm_valid     = dstrm_q.valid;

  ////////////////////////////////////////////////////////////
  // Wrapping debug counters

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_cnt <= '0;
      tx_cnt <= '0;
    end else begin
      // Registered downstream valid
      if (dstrm_q.valid)
        rx_cnt <= rx_cnt + `LL_DBG_W'(1);
      // Upstream valid only counts once rx is up
      if (ustrm_valid && rx_online)
        tx_cnt <= tx_cnt + `LL_DBG_W'(1);
    end
  end

  assign rx_debug_count = rx_cnt;
  assign tx_debug_count = tx_cnt;

  // Counters step by at most one
  a_rx_cnt_step: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (rx_cnt == $past(rx_cnt)) || (rx_cnt == $past(rx_cnt) + `LL_DBG_W'(1)));
  a_tx_cnt_step: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (tx_cnt == $past(tx_cnt)) || (tx_cnt == $past(tx_cnt) + `LL_DBG_W'(1)));

endmodule

`default_nettype wire

// ==== verilog/ll_phy_map.sv ====
// PHY word mapping of the logic link
// Transmit: marker, gated flit and strobe are registered into tx_phy.
// Receive: the flit field of rx_phy is registered, zeroed while rx is
// not yet online. Levels and user bits come from ll_sync_if.

`default_nettype none

`include "ll_config.svh"

module ll_phy_map (
  input  logic                clk_wr,
  input  logic                arst_n,
  ll_sync_if.phy              sync,
  input  lpif_pkg::lpif_flit_t tx_flit,
  output lpif_pkg::lpif_flit_t rx_flit,
  output phy_pkg::phy_word_t   tx_phy,
  input  phy_pkg::phy_word_t   rx_phy
);

  import lpif_pkg::*;

  logic [`LL_FLIT_W-1:0] tx_flit_gated;

  ////////////////////////////////////////////////////////////
  // Transmit side

  // Flit field only once tx is online, user bits run earlier
  assign tx_flit_gated = sync.tx_online_delay ? tx_flit : '0;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy <= '0;
    end else begin
      tx_phy.marker <= sync.auto_mrk;
      tx_phy.flit   <= tx_flit_gated;
      tx_phy.strobe <= sync.auto_stb;
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive side

  // Marker and strobe are not forwarded
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n)
      rx_flit <= '0;
    else if (sync.rx_online_delay)
      rx_flit <= lpif_flit_t'(rx_phy.flit);
    else
      rx_flit <= '0;
  end

  // No flit leaves while tx was down a cycle earlier
  a_tx_flit_gated: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !sync.tx_online_delay |=> (tx_phy.flit == '0));

endmodule

`default_nettype wire

// ==== verilog/lpif_ll_top.sv ====
// Top of the single-channel logic link, slave side
// Sits between the LPIF user fields and one parallel PHY word.
// Connects bring-up control, flit pack/unpack and PHY mapping; all
// ports are plain. Loop rx_phy back to tx_phy for a self test.

`default_nettype none

`include "ll_config.svh"

module lpif_ll_top (
  input  logic                   clk_wr,
  input  logic                   arst_n,

  // Bring-up requests
  input  logic                   tx_online,
  input  logic                   rx_online,

  // PHY words
  output logic [`LL_PHY_W-1:0]   tx_phy,
  input  logic [`LL_PHY_W-1:0]   rx_phy,

  // Downstream channel
  output lpif_pkg::lpif_state_e  dstrm_state,
  output lpif_pkg::lpif_protid_e dstrm_protid,
  output logic [`LL_DATA_W-1:0]  dstrm_data,
  output logic                   dstrm_dvalid,
  output logic [3:0]             dstrm_crc,
  output logic                   dstrm_crc_valid,
  output logic                   dstrm_valid,

  // Upstream channel
  input  lpif_pkg::lpif_state_e  ustrm_state,
  input  lpif_pkg::lpif_protid_e ustrm_protid,
  input  logic [`LL_DATA_W-1:0]  ustrm_data,
  input  logic                   ustrm_dvalid,
  input  logic [3:0]             ustrm_crc,
  input  logic                   ustrm_crc_valid,
  input  logic                   ustrm_valid,

  // Valid-flit counts
  output logic [`LL_DBG_W-1:0]   rx_downstream_debug_status,
  output logic [`LL_DBG_W-1:0]   tx_upstream_debug_status,

  // User bits and bring-up delays
  input  logic [`LL_MRK_W-1:0]   tx_mrk_userbit,
  input  logic                   tx_stb_userbit,
  input  logic [`LL_DLY_W-1:0]   delay_x_value,
  input  logic [`LL_DLY_W-1:0]   delay_y_value,
  input  logic [`LL_DLY_W-1:0]   delay_z_value
);

  import lpif_pkg::*;

  lpif_flit_t tx_flit;
  lpif_flit_t rx_flit;

  ll_sync_if sync_if ();

  ////////////////////////////////////////////////////////////
  // Bring-up control

  ll_auto_sync u_auto_sync (
    .clk_wr         (clk_wr),
    .arst_n         (arst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .sync           (sync_if.sync)
  );

  ////////////////////////////////////////////////////////////
  // User side, FIFO and credits bypassed

  // Tx count gated by the delayed rx level
  ll_flit_pack u_flit_pack (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .rx_flit         (rx_flit),
    .rx_online       (sync_if.rx_online_delay),
    .tx_flit         (tx_flit),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .rx_debug_count  (rx_downstream_debug_status),
    .tx_debug_count  (tx_upstream_debug_status)
  );

  ////////////////////////////////////////////////////////////
  // PHY side

  ll_phy_map u_phy_map (
    .clk_wr  (clk_wr),
    .arst_n  (arst_n),
    .sync    (sync_if.phy),
    .tx_flit (tx_flit),
    .rx_flit (rx_flit),
    .tx_phy  (tx_phy),
    .rx_phy  (rx_phy)
  );

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// Clock and reset source for the logic link testbench
// clk toggles every 2 time units, arst_n held low for 3 rising edges

`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);

  // Period 4
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Release on the third rising edge
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/tb_lpif_ll.sv ====
// Loopback testbench of the single-channel logic link
// tx_phy feeds rx_phy, so downstream fields echo the upstream ones.
// Upstream flits come from an LCG, the online levels are modelled from
// cycle counts, and concurrent assertions compare against history regs.

`default_nettype none

`include "ll_config.svh"

module tb_lpif_ll;

  import lpif_pkg::*;
  import phy_pkg::*;

  // Bring-up delays
  localparam logic [`LL_DLY_W-1:0] dly_x = `LL_DLY_W'(5);
  localparam logic [`LL_DLY_W-1:0] dly_y = `LL_DLY_W'(3);
  localparam logic [`LL_DLY_W-1:0] dly_z = `LL_DLY_W'(4);
  // About 250 driven cycles plus reset, limit over twice that
  localparam int unsigned cycle_limit = 600;

  logic                  clk_wr;
  logic                  arst_n;
  logic                  tx_online;
  logic                  rx_online;
  logic [`LL_MRK_W-1:0]  tx_mrk_userbit;
  logic                  tx_stb_userbit;
  logic [`LL_DLY_W-1:0]  delay_x_value;
  logic [`LL_DLY_W-1:0]  delay_y_value;
  logic [`LL_DLY_W-1:0]  delay_z_value;
  lpif_state_e           ustrm_state;
  lpif_protid_e          ustrm_protid;
  logic [`LL_DATA_W-1:0] ustrm_data;
  logic                  ustrm_dvalid;
  logic [3:0]            ustrm_crc;
  logic                  ustrm_crc_valid;
  logic                  ustrm_valid;
  logic [`LL_PHY_W-1:0]  tx_phy;
  lpif_state_e           dstrm_state;
  lpif_protid_e          dstrm_protid;
  logic [`LL_DATA_W-1:0] dstrm_data;
  logic                  dstrm_dvalid;
  logic [3:0]            dstrm_crc;
  logic                  dstrm_crc_valid;
  logic                  dstrm_valid;
  logic [`LL_DBG_W-1:0]  rx_dbg_status;
  logic [`LL_DBG_W-1:0]  tx_dbg_status;

  // Flat views, flit order from the top: state, protid, data, dvalid, crc, crc_valid, valid
  phy_word_t             tx_word;
  logic [`LL_FLIT_W-1:0] ustrm_vec;
  logic [`LL_FLIT_W-1:0] dstrm_vec;
  logic [`LL_MRK_W:0]    user_now;
  logic [126:0]          reset_view;

  // Online level model
  logic [`LL_DLY_W-1:0]  tx_run;
  logic [`LL_DLY_W-1:0]  tx_run_nx;
  logic [`LL_DLY_W-1:0]  rx_xs;
  logic [`LL_DLY_W-1:0]  rx_ys;
  logic                  tx_on_m;
  logic                  rx_on_m;

  // History of stimulus and modelled levels
  logic                  tx_on_h1;
  logic                  tx_on_h2;
  logic                  tx_on_h3;
  logic                  rx_on_h1;
  logic                  rx_on_h2;
  logic [`LL_FLIT_W-1:0] us_h1;
  logic [`LL_FLIT_W-1:0] us_h2;
  logic [`LL_FLIT_W-1:0] us_h3;
  logic [`LL_MRK_W:0]    user_h1;
  logic [`LL_MRK_W:0]    user_h2;
  logic [`LL_FLIT_W-1:0] exp_tx_flit;
  logic [`LL_FLIT_W-1:0] exp_dstrm;
  logic [`LL_DBG_W-1:0]  rx_cnt_m;
  logic [`LL_DBG_W-1:0]  tx_cnt_m;

  logic [31:0]           lcg_state;
  int unsigned           cycle_cnt;

  tb_clk_gen u_clk_gen (
    .clk    (clk_wr),
    .arst_n (arst_n)
  );

  // PHY loopback
  lpif_ll_top uut (
    .clk_wr                     (clk_wr),
    .arst_n                     (arst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .tx_phy                     (tx_phy),
    .rx_phy                     (tx_phy),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .rx_downstream_debug_status (rx_dbg_status),
    .tx_upstream_debug_status   (tx_dbg_status),
    .tx_mrk_userbit             (tx_mrk_userbit),
    .tx_stb_userbit             (tx_stb_userbit),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value)
  );

  assign tx_word    = tx_phy;
  assign ustrm_vec  = {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                       ustrm_crc, ustrm_crc_valid, ustrm_valid};
  assign dstrm_vec  = {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                       dstrm_crc, dstrm_crc_valid, dstrm_valid};
  assign user_now   = tx_online ? {tx_mrk_userbit, tx_stb_userbit} : '0;
  assign reset_view = {tx_phy, dstrm_vec, rx_dbg_status, tx_dbg_status};
  assign tx_run_nx  = tx_online ? tx_run + `LL_DLY_W'(1) : '0;

  // Flit field one edge after the gate level, loopback adds two more
  assign exp_tx_flit = tx_on_h1 ? us_h1 : '0;
  assign exp_dstrm   = (rx_on_h2 && tx_on_h3) ? us_h3 : '0;

  ////////////////////////////////////////////////////////////
  // Reference model and history

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_run   <= '0;
      tx_on_m  <= 1'b0;
      rx_xs    <= '0;
      rx_ys    <= '0;
      rx_on_m  <= 1'b0;
      tx_on_h1 <= 1'b0;
      tx_on_h2 <= 1'b0;
      tx_on_h3 <= 1'b0;
      rx_on_h1 <= 1'b0;
      rx_on_h2 <= 1'b0;
      us_h1    <= '0;
      us_h2    <= '0;
      us_h3    <= '0;
      user_h1  <= '0;
      user_h2  <= '0;
      rx_cnt_m <= '0;
      tx_cnt_m <= '0;
    end else begin
      // Tx up after z+1 high samples in a row
      tx_run  <= tx_run_nx;
      tx_on_m <= (tx_run_nx > dly_z);
      // Rx: x+1 high samples, then y edges with tx level up
      if (!rx_online || (rx_on_m && !tx_online)) begin
        rx_xs   <= '0;
        rx_ys   <= '0;
        rx_on_m <= 1'b0;
      end else if (!rx_on_m) begin
        if (rx_xs <= dly_x) begin
          rx_xs <= rx_xs + `LL_DLY_W'(1);
        end else if (tx_on_m) begin
          rx_ys <= rx_ys + `LL_DLY_W'(1);
          // Only goes up while tx is still requested
          if ((rx_ys + `LL_DLY_W'(1) >= dly_y) && tx_online)
            rx_on_m <= 1'b1;
        end
      end
      tx_on_h1 <= tx_on_m;
      tx_on_h2 <= tx_on_h1;
      tx_on_h3 <= tx_on_h2;
      rx_on_h1 <= rx_on_m;
      rx_on_h2 <= rx_on_h1;
      us_h1    <= ustrm_vec;
      us_h2    <= us_h1;
      us_h3    <= us_h2;
      user_h1  <= user_now;
      user_h2  <= user_h1;
      // Valid flits seen downstream, valid is bit 0
      if (exp_dstrm[0])
        rx_cnt_m <= rx_cnt_m + `LL_DBG_W'(1);
      if (ustrm_valid && rx_on_m)
        tx_cnt_m <= tx_cnt_m + `LL_DBG_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks

  a_reset_zero: assert property (@(posedge clk_wr)
    (!arst_n || !$past(arst_n)) |-> (reset_view == '0))
    else report_mismatch("reset_zero", '0, $sampled(reset_view));

  // Marker and strobe run ahead of the flit field
  a_user_bits: assert property (@(posedge clk_wr) disable iff (!arst_n)
    {tx_word.marker, tx_word.strobe} == user_h2)
    else report_mismatch("user_bits", $sampled(user_h2),
                         $sampled({tx_word.marker, tx_word.strobe}));

  a_tx_flit: assert property (@(posedge clk_wr) disable iff (!arst_n)
    tx_word.flit == exp_tx_flit)
    else report_mismatch("tx_flit", $sampled(exp_tx_flit), $sampled(tx_word.flit));

  a_dstrm: assert property (@(posedge clk_wr) disable iff (!arst_n)
    dstrm_vec == exp_dstrm)
    else report_mismatch("dstrm", $sampled(exp_dstrm), $sampled(dstrm_vec));

  a_rx_count: assert property (@(posedge clk_wr) disable iff (!arst_n)
    rx_dbg_status == rx_cnt_m)
    else report_mismatch("rx_debug", $sampled(rx_cnt_m), $sampled(rx_dbg_status));

  a_tx_count: assert property (@(posedge clk_wr) disable iff (!arst_n)
    tx_dbg_status == tx_cnt_m)
    else report_mismatch("tx_debug", $sampled(tx_cnt_m), $sampled(tx_dbg_status));

  always @(posedge clk_wr) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, stimulus never finished", cycle_cnt);
      end_with_failure();
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic lpif_state_e pick_state(input logic [2:0] sel);
    case (sel)
      3'd0:    return LPIF_ST_RESET;
      3'd1:    return LPIF_ST_ACTIVE;
      3'd2:    return LPIF_ST_IDLE;
      3'd3:    return LPIF_ST_LINKERR;
      3'd4:    return LPIF_ST_RETRAIN;
      default: return LPIF_ST_DISABLED;
    endcase
  endfunction

  task automatic end_with_failure();
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] exp_val,
                                 input logic [127:0] act_val);
    $display("FAIL %s expected %0h actual %0h", name, exp_val, act_val);
    end_with_failure();
  endtask

  // n cycles of random flits with fixed online requests and user bits
  task automatic drive_cycles(input int unsigned n, input logic txo, input logic rxo,
                              input logic [`LL_MRK_W-1:0] mrk, input logic stb);
    logic [31:0] r_data;
    logic [31:0] r_ctl;
    for (int unsigned i = 0; i < n; i++) begin
      @(posedge clk_wr);
      r_data    = lcg_next(lcg_state);
      r_ctl     = lcg_next(r_data);
      lcg_state = r_ctl;
      tx_online       <= txo;
      rx_online       <= rxo;
      tx_mrk_userbit  <= mrk;
      tx_stb_userbit  <= stb;
      ustrm_data      <= r_data;
      ustrm_state     <= pick_state(r_ctl[31:29]);
      ustrm_protid    <= lpif_protid_e'(r_ctl[28:27]);
      ustrm_dvalid    <= r_ctl[26];
      ustrm_crc       <= r_ctl[25:22];
      ustrm_crc_valid <= r_ctl[21];
      ustrm_valid     <= r_ctl[20];
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    lcg_state       = 32'd86;
    cycle_cnt       = 0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    tx_mrk_userbit  = '0;
    tx_stb_userbit  = 1'b0;
    delay_x_value   = dly_x;
    delay_y_value   = dly_y;
    delay_z_value   = dly_z;
    ustrm_state     = LPIF_ST_RESET;
    ustrm_protid    = LPIF_PROT_PCIE;
    ustrm_data      = '0;
    ustrm_dvalid    = 1'b0;
    ustrm_crc       = '0;
    ustrm_crc_valid = 1'b0;
    ustrm_valid     = 1'b0;

    // Through reset, user bits must stay masked
    drive_cycles(6, 1'b0, 1'b0, 4'h3, 1'b1);
    // Both sides up together
    drive_cycles(40, 1'b1, 1'b1, 4'h5, 1'b1);
    // Rx drop and return
    drive_cycles(3, 1'b1, 1'b0, 4'h5, 1'b1);
    drive_cycles(30, 1'b1, 1'b1, 4'h9, 1'b0);
    // Tx drop, second tx bring-up
    drive_cycles(4, 1'b0, 1'b1, 4'hA, 1'b1);
    drive_cycles(40, 1'b1, 1'b1, 4'hA, 1'b1);
    // Tx first, rx later
    drive_cycles(6, 1'b0, 1'b0, 4'h6, 1'b0);
    drive_cycles(12, 1'b1, 1'b0, 4'hC, 1'b1);
    drive_cycles(40, 1'b1, 1'b1, 4'h3, 1'b0);
    // Rx alone, y count frozen until tx returns
    drive_cycles(20, 1'b0, 1'b1, 4'hF, 1'b1);
    drive_cycles(40, 1'b1, 1'b1, 4'h7, 1'b0);
    // Wind down
    drive_cycles(12, 1'b0, 1'b0, 4'h0, 1'b0);

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verilog
verilog/lpif_pkg.sv
verilog/phy_pkg.sv
verilog/ll_sync_if.sv
verilog/ll_auto_sync.sv
verilog/ll_flit_pack.sv
verilog/ll_phy_map.sv
verilog/lpif_ll_top.sv
verif/tb_clk_gen.sv
verif/tb_lpif_ll.sv

// ==== run.sh ====
#!/bin/sh
# Build the loopback testbench with Verilator and run it
verilator --binary --timing --assert -f list.f --top-module tb_lpif_ll \
  && ./obj_dir/Vtb_lpif_ll | tee /dev/stderr | grep "TB PASSED" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
